/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 -f flist.f \
		--top-module sharedFifoTb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/VsharedFifoTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* flist.f */
verilog/fifoParamPkg.sv
verilog/fifoPtrPkg.sv
verilog/fifoPtrIf.sv
verilog/pushCtrl.sv
verilog/popCtrl.sv
verilog/ptrManager.sv
verilog/sharedRam.sv
verilog/sharedFifo.sv
verification/sharedFifoTb.sv

/* verification/sharedFifoTb.sv */
/* Directed testbench for the shared multi-FIFO, with one queue
   model per FIFO that predicts ready, valid and every popped word */
`timescale 1ns/1ns
`default_nettype none

module sharedFifoTb import fifoParamPkg::*;;
  localparam int NumFifos = 4;
  localparam int Depth = 16;
  localparam int Width = 8;
  localparam int AddrWidth = clampedClog2(Depth);
  localparam int FifoIdWidth = clampedClog2(NumFifos);
  // Each region spans base to base plus 3
  localparam int RegionEntries = 4;
  localparam int RandomCycles = 300;
  // Directed tests plus draining stay well under 100 cycles beyond the random run
  localparam int TimeoutCycles = 5 * (RandomCycles + 100);

  logic clk = 1'b0;
  logic reset;
  logic [NumFifos-1:0][AddrWidth-1:0] configBase;
  logic [NumFifos-1:0][AddrWidth-1:0] configBound;
  logic pushValid;
  logic pushReady;
  logic [Width-1:0] pushData;
  logic [FifoIdWidth-1:0] pushFifoId;
  logic [FifoIdWidth-1:0] popFifoId;
  logic popValid;
  logic popReady;
  logic [Width-1:0] popData;

  // Expected contents of every FIFO, front is the head
  logic [Width-1:0] model [NumFifos][$];
  int dataErrors = 0;
  int flagErrors = 0;
  int cycleCount = 0;

  sharedFifo #(.NumFifos(NumFifos), .Depth(Depth), .Width(Width)) dut0 (
    .clk(clk), .reset(reset),
    .configBase(configBase), .configBound(configBound),
    .pushValid(pushValid), .pushReady(pushReady),
    .pushData(pushData), .pushFifoId(pushFifoId),
    .popFifoId(popFifoId), .popValid(popValid),
    .popReady(popReady), .popData(popData)
  );

  always #50 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic checkFlag(input string testName, input logic expected, input logic actual);
    if (actual !== expected) begin
      flagErrors++;
      $display("error: %s expected %b actual %b", testName, expected, actual);
    end
  endtask

  task automatic checkData(input string testName, input logic [Width-1:0] expected,
                           input logic [Width-1:0] actual);
    if (actual !== expected) begin
      dataErrors++;
      $display("error: %s expected %h actual %h", testName, expected, actual);
    end
  endtask

  // One clock cycle, entered and left 10 ns after a rising edge
  // Checks mid cycle, then applies the beats the model predicts
  task automatic runCycle(input string testName, input logic pushV,
                          input logic [FifoIdWidth-1:0] pushId, input logic [Width-1:0] data,
                          input logic [FifoIdWidth-1:0] popId, input logic popR);
    logic expReady;
    logic expValid;
    pushValid = pushV;
    pushFifoId = pushId;
    pushData = data;
    popFifoId = popId;
    popReady = popR;
    expReady = model[pushId].size() < RegionEntries;
    expValid = model[popId].size() != 0;
    #40;
    checkFlag({testName, " pushReady"}, expReady, pushReady);
    checkFlag({testName, " popValid"}, expValid, popValid);
    if (expValid) begin
      checkData({testName, " popData"}, model[popId][0], popData);
    end
    @(posedge clk);
    // Pop reads the old head, so take it before adding the push
    if (popR && expValid) begin
      void'(model[popId].pop_front());
    end
    if (pushV && expReady) begin
      model[pushId].push_back(data);
    end
    #10;
  endtask

  task automatic drainAll(input string testName);
    for (int id = 0; id < NumFifos; id++) begin
      while (model[id].size() != 0) begin
        runCycle(testName, 1'b0, '0, '0, FifoIdWidth'(id), 1'b1);
      end
    end
  endtask

  task automatic afterResetTest();
    for (int id = 0; id < NumFifos; id++) begin
      runCycle("afterReset", 1'b0, FifoIdWidth'(id), '0, FifoIdWidth'(id), 1'b0);
    end
  endtask

  // popValid rises the cycle after the first push
  task automatic singleFifoOrderTest();
    for (int n = 0; n < 3; n++) begin
      runCycle("singleOrder", 1'b1, 2'd1, Width'(8'hA0 + n), 2'd1, 1'b0);
    end
    drainAll("singleOrder");
  endtask

  task automatic interleavedTest();
    for (int round = 0; round < 2; round++) begin
      for (int id = 0; id < NumFifos; id++) begin
        runCycle("interleaved", 1'b1, FifoIdWidth'(id), Width'(16 * id + round + 1),
                 FifoIdWidth'(id), 1'b0);
      end
    end
    drainAll("interleaved");
  endtask

  // Fill FIFO 2, probe every id, try a blocked push, then free one slot
  task automatic fullBlockTest();
    for (int n = 0; n < RegionEntries; n++) begin
      runCycle("fullBlock", 1'b1, 2'd2, Width'(8'h50 + n), 2'd0, 1'b0);
    end
    for (int id = 0; id < NumFifos; id++) begin
      runCycle("fullBlock", 1'b0, FifoIdWidth'(id), '0, 2'd2, 1'b0);
    end
    runCycle("fullBlock", 1'b1, 2'd2, 8'hEE, 2'd2, 1'b0);
    runCycle("fullBlock", 1'b0, 2'd2, '0, 2'd2, 1'b1);
    runCycle("fullBlock", 1'b0, 2'd2, '0, 2'd2, 1'b0);
    drainAll("fullBlock");
  endtask

  // Ten words pass through a 4 entry region, so both pointers wrap
  task automatic wrapTest();
    runCycle("wrap", 1'b1, 2'd3, 8'h71, 2'd3, 1'b0);
    runCycle("wrap", 1'b1, 2'd3, 8'h72, 2'd3, 1'b0);
    for (int n = 0; n < 8; n++) begin
      runCycle("wrap", 1'b1, 2'd3, Width'(8'h80 + n), 2'd3, 1'b1);
    end
    drainAll("wrap");
  endtask

  task automatic randomMixTest();
    for (int n = 0; n < RandomCycles; n++) begin
      runCycle("randomMix", 1'($urandom_range(1)), FifoIdWidth'($urandom_range(NumFifos - 1)),
               Width'($urandom), FifoIdWidth'($urandom_range(NumFifos - 1)),
               1'($urandom_range(1)));
    end
    drainAll("randomMix");
  endtask

  initial begin
    void'($urandom(14308));
    reset = 1'b1;
    pushValid = 1'b0;
    pushData = '0;
    pushFifoId = '0;
    popFifoId = '0;
    popReady = 1'b0;
    for (int id = 0; id < NumFifos; id++) begin
      configBase[id] = AddrWidth'(RegionEntries * id);
      configBound[id] = AddrWidth'(RegionEntries * id + RegionEntries - 1);
    end
    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;
    afterResetTest();
    singleFifoOrderTest();
    interleavedTest();
    fullBlockTest();
    wrapTest();
    randomMixTest();
    $display("Errors: data %0d, flag %0d", dataErrors, flagErrors);
    if (dataErrors + flagErrors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/fifoParamPkg.sv */
/* Size defaults for the shared multi-FIFO and the helper that
   derives address and FIFO id widths from them */
`default_nettype none

package fifoParamPkg;

  // Defaults only, the top level sets the real values
  parameter int DefaultNumFifos = 4;
  parameter int DefaultDepth = 16;
  parameter int DefaultWidth = 8;

  // Ceiling of log2, never narrower than one bit
  function automatic int clampedClog2(input int value);
    int bits;
    bits = $clog2(value);
    if (bits < 1) begin
      bits = 1;
    end
    return bits;
  endfunction

endpackage

`default_nettype wire

/* verilog/fifoPtrIf.sv */
/* Pointer update bundle between the push and pop controllers
   and the pointer manager that turns it into full and empty */
`timescale 1ns/1ns
`default_nettype none

interface fifoPtrIf import fifoParamPkg::*; #(
  parameter int NumFifos = DefaultNumFifos,
  parameter int AddrWidth = clampedClog2(DefaultDepth)
);

  // Tail side, one advance bit per FIFO
  logic [NumFifos-1:0] advanceTail;
  logic [NumFifos-1:0][AddrWidth-1:0] tailNext;

  // Head side, one advance bit per FIFO
  logic [NumFifos-1:0] advanceHead;
  logic [NumFifos-1:0][AddrWidth-1:0] headNext;

  // Occupancy status from the manager
  logic [NumFifos-1:0] full;
  logic [NumFifos-1:0] empty;

  modport push (
    output advanceTail, tailNext,
    input full
  );

  modport pop (
    output advanceHead, headNext,
    input empty
  );

  modport mgr (
    input advanceTail, advanceHead,
    output full, empty
  );

endinterface

`default_nettype wire

/* verilog/fifoPtrPkg.sv */
/* Circular pointer arithmetic for a FIFO region
   bounded by an inclusive base and bound address */
`default_nettype none

package fifoPtrPkg;

  // Next slot after addr inside [base, bound]
  // Wraps back to base once the bound is reached
  function automatic int unsigned wrapIncrement(
    input int unsigned addr,
    input int unsigned base,
    input int unsigned bound
  );
    int unsigned nextAddr;
    if (addr == bound) begin
      nextAddr = base;
    end else begin
      nextAddr = addr + 1;
    end
    return nextAddr;
  endfunction

  // Number of entries a region holds
  // Base and bound are both inclusive
  function automatic int unsigned regionSize(
    input int unsigned base,
    input int unsigned bound
  );
    int unsigned entries;
    // Region is expected to be well formed, bound not below base
    if (bound < base) begin
      entries = 0;
    end else begin
      entries = bound - base + 1;
    end
    return entries;
  endfunction

endpackage

`default_nettype wire

/* verilog/popCtrl.sv */
/* Pop side of the shared multi-FIFO: holds each FIFO's head,
   reads storage at the selected head and steps it on a pop beat */
`timescale 1ns/1ns
`default_nettype none

module popCtrl import fifoParamPkg::*, fifoPtrPkg::*; #(
  parameter int NumFifos = DefaultNumFifos,
  parameter int Depth = DefaultDepth,
  parameter int Width = DefaultWidth
) (
  input wire logic clk,
  input wire logic reset,

  // Static region of each FIFO
  input wire logic [NumFifos-1:0][clampedClog2(Depth)-1:0] configBase,
  input wire logic [NumFifos-1:0][clampedClog2(Depth)-1:0] configBound,

  // Pop port
  input wire logic [clampedClog2(NumFifos)-1:0] popFifoId,
  output logic popValid,
  input wire logic popReady,
  output logic [Width-1:0] popData,

  // Pointer updates to the manager
  fifoPtrIf.pop ptr,

  // Storage read port, no latency
  output logic [clampedClog2(Depth)-1:0] rdAddr,
  input wire logic [Width-1:0] rdData
);

  localparam int AddrWidth = clampedClog2(Depth);
  localparam int FifoIdWidth = clampedClog2(NumFifos);

  logic [NumFifos-1:0][AddrWidth-1:0] head;
  logic idInRange;
  logic popBeat;

  assign idInRange = int'(popFifoId) < NumFifos;

  // Valid as soon as the selected FIFO holds anything
  assign popValid = idInRange && !ptr.empty[popFifoId];

  // Head entry comes straight out of storage
  assign rdAddr = head[popFifoId];
  assign popData = rdData;

  assign popBeat = popValid && popReady && !reset;

  for (genvar i = 0; i < NumFifos; i++) begin : genHead
    assign ptr.advanceHead[i] = popBeat && (popFifoId == FifoIdWidth'(i));
    assign ptr.headNext[i] =
        AddrWidth'(wrapIncrement(head[i], configBase[i], configBound[i]));
  end

  // Head registers start at the region base
  always_ff @(posedge clk) begin
    for (int i = 0; i < NumFifos; i++) begin
      if (reset) begin
        head[i] <= configBase[i];
      end else if (ptr.advanceHead[i]) begin
        head[i] <= ptr.headNext[i];
      end
    end
  end

  // Manager status must keep pops off empty FIFOs
  noPopWhenEmpty: assert property (
    @(posedge clk) disable iff (reset)
    (ptr.advanceHead & ptr.empty) == '0
  );

  // Stalled head data holds while the same FIFO stays selected
  // Concurrent pushes land at the tail and leave it alone
  headHeldWhenStalled: assert property (
    @(posedge clk) disable iff (reset)
    (popValid && !popReady) ##1 $stable(popFifoId) |-> $stable(popData)
  );

endmodule

`default_nettype wire

/* verilog/ptrManager.sv */
/* Occupancy tracking for the shared multi-FIFO: one count per FIFO
   built from tail and head advances, giving full and empty */
`timescale 1ns/1ns
`default_nettype none

module ptrManager import fifoParamPkg::*, fifoPtrPkg::*; #(
  parameter int NumFifos = DefaultNumFifos,
  parameter int Depth = DefaultDepth,
  parameter int Width = DefaultWidth
) (
  input wire logic clk,
  input wire logic reset,

  // Static region of each FIFO
  input wire logic [NumFifos-1:0][clampedClog2(Depth)-1:0] configBase,
  input wire logic [NumFifos-1:0][clampedClog2(Depth)-1:0] configBound,

  // Advances in, status out
  fifoPtrIf.mgr ptr
);

  // Wide enough for a region spanning the whole storage
  localparam int CountWidth = clampedClog2(Depth + 1);

  logic [NumFifos-1:0][CountWidth-1:0] count;
  logic [NumFifos-1:0][CountWidth-1:0] regionLimit;

  // Region capacity follows the static base and bound
  for (genvar i = 0; i < NumFifos; i++) begin : genLimit
    assign regionLimit[i] = CountWidth'(regionSize(configBase[i], configBound[i]));
  end

  // Push adds, pop removes, both at once leaves the count alone
  always_ff @(posedge clk) begin
    for (int i = 0; i < NumFifos; i++) begin
      if (reset) begin
        count[i] <= '0;
      end else begin
        case ({ptr.advanceTail[i], ptr.advanceHead[i]})
          2'b10: count[i] <= count[i] + 1'b1;
          2'b01: count[i] <= count[i] - 1'b1;
          default: count[i] <= count[i];
        endcase
      end
    end
  end

  // Status is a pure decode of the registered count
  for (genvar i = 0; i < NumFifos; i++) begin : genStatus
    assign ptr.full[i] = count[i] == regionLimit[i];
    assign ptr.empty[i] = count[i] == '0;

    // Push gating on full keeps every FIFO within its region
    countWithinRegion: assert property (
      @(posedge clk) disable iff (reset)
      count[i] <= regionLimit[i]
    );
  end

  // Sane parameter set: a payload bit and an entry for every FIFO
  initial begin
    if (Width < 1) begin
      $error("ptrManager: Width must be at least 1");
    end
    if (NumFifos > Depth) begin
      $error("ptrManager: each FIFO needs at least one entry");
    end
  end

endmodule

`default_nettype wire

/* verilog/pushCtrl.sv */
/* Push side of the shared multi-FIFO: steers each push to its FIFO,
   writes storage at that FIFO's tail and steps the tail in its region */
`timescale 1ns/1ns
`default_nettype none

module pushCtrl import fifoParamPkg::*, fifoPtrPkg::*; #(
  parameter int NumFifos = DefaultNumFifos,
  parameter int Depth = DefaultDepth,
  parameter int Width = DefaultWidth
) (
  input wire logic clk,
  input wire logic reset,

  // Static region of each FIFO, changed only under reset
  input wire logic [NumFifos-1:0][clampedClog2(Depth)-1:0] configBase,
  input wire logic [NumFifos-1:0][clampedClog2(Depth)-1:0] configBound,

  // Push port
  input wire logic pushValid,
  output logic pushReady,
  input wire logic [Width-1:0] pushData,
  input wire logic [clampedClog2(NumFifos)-1:0] pushFifoId,

  // Pointer updates to the manager
  fifoPtrIf.push ptr,

  // Storage write port
  output logic wrValid,
  output logic [clampedClog2(Depth)-1:0] wrAddr,
  output logic [Width-1:0] wrData
);

  localparam int AddrWidth = clampedClog2(Depth);
  localparam int FifoIdWidth = clampedClog2(NumFifos);

  logic [NumFifos-1:0][AddrWidth-1:0] tail;
  logic idInRange;
  logic pushBeat;

  // Ids past NumFifos never see ready
  assign idInRange = int'(pushFifoId) < NumFifos;

  // Only the named FIFO can stall the port
  assign pushReady = idInRange && !ptr.full[pushFifoId];

  // No beat is taken while reset is held
  assign pushBeat = pushValid && pushReady && !reset;

  // One-hot decode of the id and next tail per FIFO
  for (genvar i = 0; i < NumFifos; i++) begin : genTail
    assign ptr.advanceTail[i] = pushBeat && (pushFifoId == FifoIdWidth'(i));
    assign ptr.tailNext[i] =
        AddrWidth'(wrapIncrement(tail[i], configBase[i], configBound[i]));
  end

  // Tail registers, loaded from the region base on reset
  always_ff @(posedge clk) begin
    for (int i = 0; i < NumFifos; i++) begin
      if (reset) begin
        tail[i] <= configBase[i];
      end else if (ptr.advanceTail[i]) begin
        tail[i] <= ptr.tailNext[i];
      end
    end
  end

  // Storage write lands at the current tail in the beat cycle
  assign wrValid = pushBeat;
  assign wrAddr = tail[pushFifoId];
  assign wrData = pushData;

  // At most one FIFO takes a push per cycle
  advanceTailOneHot: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(ptr.advanceTail)
  );

  // A FIFO reported full by the manager never takes a push
  noPushWhenFull: assert property (
    @(posedge clk) disable iff (reset)
    (ptr.advanceTail & ptr.full) == '0
  );

endmodule

`default_nettype wire

/* verilog/sharedFifo.sv */
/* Shared pseudo-static multi-FIFO: push and pop controllers, pointer
   manager and one storage array, all regions fixed while out of reset */
`timescale 1ns/1ns
`default_nettype none

module sharedFifo import fifoParamPkg::*; #(
  parameter int NumFifos = DefaultNumFifos,
  parameter int Depth = DefaultDepth,
  parameter int Width = DefaultWidth
) (
  input wire logic clk,
  input wire logic reset,

  // Per FIFO region, inclusive base and bound
  input wire logic [NumFifos-1:0][clampedClog2(Depth)-1:0] configBase,
  input wire logic [NumFifos-1:0][clampedClog2(Depth)-1:0] configBound,

  // Push port, FIFO chosen by id
  input wire logic pushValid,
  output logic pushReady,
  input wire logic [Width-1:0] pushData,
  input wire logic [clampedClog2(NumFifos)-1:0] pushFifoId,

  // Pop port, FIFO chosen by id
  input wire logic [clampedClog2(NumFifos)-1:0] popFifoId,
  output logic popValid,
  input wire logic popReady,
  output logic [Width-1:0] popData
);

  localparam int AddrWidth = clampedClog2(Depth);

  // Storage write and read paths
  logic wrValid;
  logic [AddrWidth-1:0] wrAddr;
  logic [Width-1:0] wrData;
  logic [AddrWidth-1:0] rdAddr;
  logic [Width-1:0] rdData;

  fifoPtrIf #(.NumFifos(NumFifos), .AddrWidth(AddrWidth)) ptrBus ();

  pushCtrl #(.NumFifos(NumFifos), .Depth(Depth), .Width(Width)) pushCtrl0 (
    .clk(clk), .reset(reset),
    .configBase(configBase), .configBound(configBound),
    .pushValid(pushValid), .pushReady(pushReady),
    .pushData(pushData), .pushFifoId(pushFifoId),
    .ptr(ptrBus.push),
    .wrValid(wrValid), .wrAddr(wrAddr), .wrData(wrData)
  );

  popCtrl #(.NumFifos(NumFifos), .Depth(Depth), .Width(Width)) popCtrl0 (
    .clk(clk), .reset(reset),
    .configBase(configBase), .configBound(configBound),
    .popFifoId(popFifoId), .popValid(popValid),
    .popReady(popReady), .popData(popData),
    .ptr(ptrBus.pop),
    .rdAddr(rdAddr), .rdData(rdData)
  );

  // Turns both sides' advances into full and empty
  ptrManager #(.NumFifos(NumFifos), .Depth(Depth), .Width(Width)) ptrManager0 (
    .clk(clk), .reset(reset),
    .configBase(configBase), .configBound(configBound),
    .ptr(ptrBus.mgr)
  );

  sharedRam #(.NumFifos(NumFifos), .Depth(Depth), .Width(Width)) sharedRam0 (
    .clk(clk),
    .wrValid(wrValid), .wrAddr(wrAddr), .wrData(wrData),
    .rdAddr(rdAddr), .rdData(rdData)
  );

endmodule

`default_nettype wire

/* verilog/sharedRam.sv */
/* Flop storage shared by all FIFOs, one write port
   and one combinational read port */
`timescale 1ns/1ns
`default_nettype none

module sharedRam import fifoParamPkg::*; #(
  parameter int NumFifos = DefaultNumFifos,
  parameter int Depth = DefaultDepth,
  parameter int Width = DefaultWidth
) (
  input wire logic clk,

  // Write port from the push side
  input wire logic wrValid,
  input wire logic [clampedClog2(Depth)-1:0] wrAddr,
  input wire logic [Width-1:0] wrData,

  // Read port for the pop side
  input wire logic [clampedClog2(Depth)-1:0] rdAddr,
  output logic [Width-1:0] rdData
);

  // One word per entry, split among the FIFO regions
  logic [Width-1:0] mem [Depth];

  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Read sees the array directly, no added cycle
  assign rdData = mem[rdAddr];

  // Regions are set up so that every tail stays inside the array
  wrAddrInRange: assert property (
    @(posedge clk)
    wrValid |-> int'(wrAddr) < Depth
  );

  // Storage must leave room for every FIFO
  initial begin
    if (NumFifos > Depth) begin
      $error("sharedRam: fewer entries than FIFOs");
    end
  end

endmodule

`default_nettype wire
